// ==== hw/tcp_rx_pkg.sv ====
package tcp_rx_pkg;

    localparam int FLOW_CNT = 16;
    localparam int LANE_CNT = 4;
    localparam int FLOWID_W = 4;
    localparam int LANE_W   = 2;
    localparam int SLOT_W   = 2;
    localparam int SEQ_W    = 32;
    localparam int FLAGS_W  = 8;

    // bit positions in the tcp flag byte
    localparam int FLAG_FIN = 0;
    localparam int FLAG_SYN = 1;
    localparam int FLAG_RST = 2;
    localparam int FLAG_PSH = 3;
    localparam int FLAG_ACK = 4;

    localparam logic [SEQ_W-1:0] INIT_SEQ = 32'h0000_1000;

    localparam int IN_DEPTH    = 4;
    localparam int HDR_DEPTH   = 2;
    localparam int RPL_DEPTH   = 2;
    localparam int OUT_CREDITS = 4;

    // credit counter widths, sized to hold the full starting value
    localparam int HDR_CNT_W = $clog2(HDR_DEPTH + 1);
    localparam int OUT_CNT_W = $clog2(OUT_CREDITS + 1);

    typedef enum logic [1:0] {
        ST_NONE     = 2'd0,
        ST_SYN_RCVD = 2'd1,
        ST_EST      = 2'd2
    } flow_state_e;

    typedef struct packed {
        logic [FLOWID_W-1:0] flowid;
        logic [FLAGS_W-1:0]  flags;
        logic [SEQ_W-1:0]    seq;
        logic [SEQ_W-1:0]    ack;
    } rx_hdr_t;

    typedef struct packed {
        logic [FLOWID_W-1:0] flowid;
        logic [FLAGS_W-1:0]  flags;
        logic [SEQ_W-1:0]    seq;
        logic [SEQ_W-1:0]    ack;
    } reply_hdr_t;

endpackage

// ==== hw/credit_fifo.sv ====
`timescale 1ns/10ps
module credit_fifo #(
     parameter type item_t = logic [7:0]
    ,parameter int  DEPTH  = 2
) (
     input                  clk
    ,input                  rst

    ,input                  push
    ,input  item_t          push_data
    ,input                  pop
    ,output item_t          head
    ,output logic           not_empty
    ,output logic           not_full
    ,output logic           credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t              mem [DEPTH];
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W-1:0]   wr_ptr;
    logic [CNT_W-1:0]   count;

    logic               do_push;
    logic               do_pop;

    assign do_push = push && not_full;
    assign do_pop  = pop && not_empty;

    assign not_empty = (count != '0);
    assign not_full  = (count != CNT_W'(DEPTH));
    assign head      = mem[rd_ptr];
    // one credit back to the sender per entry freed
    assign credit    = do_pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end
endmodule

// ==== hw/tcp_state_decide.sv ====
`timescale 1ns/10ps
module tcp_state_decide
import tcp_rx_pkg::*;
(
     input  flow_state_e    cur_state
    ,input  rx_hdr_t        hdr

    ,output flow_state_e    next_state
    ,output logic           reply_val
    ,output reply_hdr_t     reply
);

    logic   is_fin;
    logic   is_syn;
    logic   is_rst;
    logic   is_ack;

    assign is_fin = hdr.flags[FLAG_FIN];
    assign is_syn = hdr.flags[FLAG_SYN];
    assign is_rst = hdr.flags[FLAG_RST];
    assign is_ack = hdr.flags[FLAG_ACK];

    always_comb begin
        next_state   = cur_state;
        reply_val    = 1'b0;
        reply        = '0;
        reply.flowid = hdr.flowid;

        // checked in priority order
        if (is_rst) begin
            next_state = ST_NONE;
        end
        else if (is_syn && !is_ack && (cur_state == ST_NONE)) begin
            next_state  = ST_SYN_RCVD;
            reply_val   = 1'b1;
            reply.flags = '0;
            reply.flags[FLAG_SYN] = 1'b1;
            reply.flags[FLAG_ACK] = 1'b1;
            reply.seq   = INIT_SEQ;
            reply.ack   = hdr.seq + 1'b1;
        end
        else if (is_ack && !is_syn && !is_fin && (cur_state == ST_SYN_RCVD)) begin
            next_state = ST_EST;
        end
        else if (is_fin && (cur_state == ST_EST)) begin
            // close: ack the fin, echo peer's ack as our seq
            next_state  = ST_NONE;
            reply_val   = 1'b1;
            reply.flags = '0;
            reply.flags[FLAG_ACK] = 1'b1;
            reply.seq   = hdr.ack;
            reply.ack   = hdr.seq + 1'b1;
        end
    end
endmodule

// ==== hw/rx_hdr_dispatch.sv ====
`timescale 1ns/10ps
module rx_hdr_dispatch
import tcp_rx_pkg::*;
(
     input                          clk
    ,input                          rst

    ,input                          hdr_valid
    ,input          [FLOWID_W-1:0]  hdr_flowid
    ,input          [FLAGS_W-1:0]   hdr_flags
    ,input          [SEQ_W-1:0]     hdr_seq
    ,input          [SEQ_W-1:0]     hdr_ack
    ,output logic                   hdr_credit

    ,output logic   [LANE_CNT-1:0]  lane_push
    ,output rx_hdr_t                lane_hdr
    ,input          [LANE_CNT-1:0]  lane_credit
);

    rx_hdr_t                in_hdr;
    logic                   in_not_empty;
    logic                   in_pop;
    logic [LANE_W-1:0]      lane_sel;
    logic [HDR_CNT_W-1:0]   lane_cnt [LANE_CNT];

    assign in_hdr.flowid = hdr_flowid;
    assign in_hdr.flags  = hdr_flags;
    assign in_hdr.seq    = hdr_seq;
    assign in_hdr.ack    = hdr_ack;

    // the sender holds credits, so the queue is never pushed while full
    credit_fifo #(
         .item_t    (rx_hdr_t)
        ,.DEPTH     (IN_DEPTH)
    ) i_in_fifo (
         .clk       (clk)
        ,.rst       (rst)
        ,.push      (hdr_valid)
        ,.push_data (in_hdr)
        ,.pop       (in_pop)
        ,.head      (lane_hdr)
        ,.not_empty (in_not_empty)
        ,.not_full  ()
        ,.credit    (hdr_credit)
    );

    // low flow id bits pick the lane
    assign lane_sel = lane_hdr.flowid[LANE_W-1:0];
    assign in_pop   = in_not_empty && (lane_cnt[lane_sel] != '0);

    always_comb begin
        lane_push = '0;
        if (in_pop) begin
            lane_push[lane_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LANE_CNT; i++) begin
                lane_cnt[i] <= HDR_CNT_W'(HDR_DEPTH);
            end
        end
        else begin
            for (int i = 0; i < LANE_CNT; i++) begin
                lane_cnt[i] <= lane_cnt[i] - HDR_CNT_W'(lane_push[i])
                                           + HDR_CNT_W'(lane_credit[i]);
            end
        end
    end
endmodule

// ==== hw/rx_flow_lane.sv ====
`timescale 1ns/10ps
module rx_flow_lane
import tcp_rx_pkg::*;
(
     input                  clk
    ,input                  rst

    ,input                  push
    ,input  rx_hdr_t        push_hdr
    ,output logic           credit

    ,output logic           rpl_valid
    ,output reply_hdr_t     rpl_head
    ,input                  rpl_pop
);

    typedef enum logic {
        IDLE   = 1'b0,
        DECIDE = 1'b1
    } lane_state_e;

    lane_state_e        ctrl_state;
    flow_state_e        state_tbl [FLOW_CNT/LANE_CNT];

    rx_hdr_t            q_head;
    logic               q_not_empty;
    logic               q_pop;
    rx_hdr_t            hold_hdr;
    logic [SLOT_W-1:0]  slot;

    flow_state_e        next_state;
    logic               reply_val;
    reply_hdr_t         reply;
    logic               rpl_not_full;
    logic               rpl_push;
    logic               advance;

    credit_fifo #(
         .item_t    (rx_hdr_t)
        ,.DEPTH     (HDR_DEPTH)
    ) i_hdr_fifo (
         .clk       (clk)
        ,.rst       (rst)
        ,.push      (push)
        ,.push_data (push_hdr)
        ,.pop       (q_pop)
        ,.head      (q_head)
        ,.not_empty (q_not_empty)
        ,.not_full  ()
        ,.credit    (credit)
    );

    // high flow id bits index the flow within this lane
    assign slot = hold_hdr.flowid[FLOWID_W-1 -: SLOT_W];

    tcp_state_decide i_decide (
         .cur_state     (state_tbl[slot])
        ,.hdr           (hold_hdr)
        ,.next_state    (next_state)
        ,.reply_val     (reply_val)
        ,.reply         (reply)
    );

    assign q_pop    = (ctrl_state == IDLE) && q_not_empty;
    // stall in decide until the reply fits
    assign advance  = (ctrl_state == DECIDE) && (!reply_val || rpl_not_full);
    assign rpl_push = advance && reply_val;

    always_ff @(posedge clk) begin
        if (q_pop) begin
            hold_hdr <= q_head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_state <= IDLE;
            for (int i = 0; i < FLOW_CNT/LANE_CNT; i++) begin
                state_tbl[i] <= ST_NONE;
            end
        end
        else begin
            if (q_pop) begin
                ctrl_state <= DECIDE;
            end
            else if (advance) begin
                ctrl_state      <= IDLE;
                state_tbl[slot] <= next_state;
            end
        end
    end

    credit_fifo #(
         .item_t    (reply_hdr_t)
        ,.DEPTH     (RPL_DEPTH)
    ) i_rpl_fifo (
         .clk       (clk)
        ,.rst       (rst)
        ,.push      (rpl_push)
        ,.push_data (reply)
        ,.pop       (rpl_pop)
        ,.head      (rpl_head)
        ,.not_empty (rpl_valid)
        ,.not_full  (rpl_not_full)
        ,.credit    ()
    );
endmodule

// ==== hw/reply_arbiter.sv ====
`timescale 1ns/10ps
module reply_arbiter
import tcp_rx_pkg::*;
(
     input                          clk
    ,input                          rst

    ,input          [LANE_CNT-1:0]  rpl_valid
    ,input  reply_hdr_t             rpl_head [LANE_CNT]
    ,output logic   [LANE_CNT-1:0]  rpl_pop

    ,output logic                   reply_valid
    ,output logic   [FLOWID_W-1:0]  reply_flowid
    ,output logic   [FLAGS_W-1:0]   reply_flags
    ,output logic   [SEQ_W-1:0]     reply_seq
    ,output logic   [SEQ_W-1:0]     reply_ack
    ,input                          reply_credit
);

    logic [LANE_W-1:0]      rr_ptr;
    logic [LANE_W-1:0]      sel;
    logic                   found;
    logic [OUT_CNT_W-1:0]   out_cnt;
    reply_hdr_t             sel_hdr;

    // first valid lane at or after the pointer
    always_comb begin
        logic [LANE_W-1:0] idx;
        found = 1'b0;
        sel   = rr_ptr;
        for (int k = 0; k < LANE_CNT; k++) begin
            idx = rr_ptr + LANE_W'(k);
            if (!found && rpl_valid[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign reply_valid = found && (out_cnt != '0);
    assign sel_hdr     = rpl_head[sel];

    always_comb begin
        rpl_pop = '0;
        if (reply_valid) begin
            rpl_pop[sel] = 1'b1;
        end
    end

    assign reply_flowid = sel_hdr.flowid;
    assign reply_flags  = sel_hdr.flags;
    assign reply_seq    = sel_hdr.seq;
    assign reply_ack    = sel_hdr.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr  <= '0;
            out_cnt <= OUT_CNT_W'(OUT_CREDITS);
        end
        else begin
            if (reply_valid) begin
                rr_ptr <= sel + 1'b1;
            end
            out_cnt <= out_cnt - OUT_CNT_W'(reply_valid) + OUT_CNT_W'(reply_credit);
        end
    end
endmodule

// ==== hw/tcp_rx_top.sv ====
`timescale 1ns/10ps
module tcp_rx_top
import tcp_rx_pkg::*;
(
     input                          clk
    ,input                          rst

    ,input                          hdr_valid
    ,input          [FLOWID_W-1:0]  hdr_flowid
    ,input          [FLAGS_W-1:0]   hdr_flags
    ,input          [SEQ_W-1:0]     hdr_seq
    ,input          [SEQ_W-1:0]     hdr_ack
    ,output logic                   hdr_credit

    ,output logic                   reply_valid
    ,output logic   [FLOWID_W-1:0]  reply_flowid
    ,output logic   [FLAGS_W-1:0]   reply_flags
    ,output logic   [SEQ_W-1:0]     reply_seq
    ,output logic   [SEQ_W-1:0]     reply_ack
    ,input                          reply_credit
);

    logic   [LANE_CNT-1:0]  lane_push;
    rx_hdr_t                lane_hdr;
    logic   [LANE_CNT-1:0]  lane_credit;
    logic   [LANE_CNT-1:0]  rpl_valid;
    reply_hdr_t             rpl_head [LANE_CNT];
    logic   [LANE_CNT-1:0]  rpl_pop;

    rx_hdr_dispatch i_dispatch (
         .clk           (clk)
        ,.rst           (rst)
        ,.hdr_valid     (hdr_valid)
        ,.hdr_flowid    (hdr_flowid)
        ,.hdr_flags     (hdr_flags)
        ,.hdr_seq       (hdr_seq)
        ,.hdr_ack       (hdr_ack)
        ,.hdr_credit    (hdr_credit)
        ,.lane_push     (lane_push)
        ,.lane_hdr      (lane_hdr)
        ,.lane_credit   (lane_credit)
    );

    for (genvar g = 0; g < LANE_CNT; g++) begin : g_lane
        rx_flow_lane i_lane (
             .clk       (clk)
            ,.rst       (rst)
            ,.push      (lane_push[g])
            ,.push_hdr  (lane_hdr)
            ,.credit    (lane_credit[g])
            ,.rpl_valid (rpl_valid[g])
            ,.rpl_head  (rpl_head[g])
            ,.rpl_pop   (rpl_pop[g])
        );
    end

    reply_arbiter i_arbiter (
         .clk           (clk)
        ,.rst           (rst)
        ,.rpl_valid     (rpl_valid)
        ,.rpl_head      (rpl_head)
        ,.rpl_pop       (rpl_pop)
        ,.reply_valid   (reply_valid)
        ,.reply_flowid  (reply_flowid)
        ,.reply_flags   (reply_flags)
        ,.reply_seq     (reply_seq)
        ,.reply_ack     (reply_ack)
        ,.reply_credit  (reply_credit)
    );
endmodule

// ==== sim/tcp_rx_assert.sv ====
`timescale 1ns/10ps
module tcp_rx_assert
import tcp_rx_pkg::*;
(
     input                          clk
    ,input                          rst
    ,input                          reply_valid
    ,input                          reply_credit
    ,input          [OUT_CNT_W-1:0] out_cnt
    ,input          [HDR_CNT_W-1:0] lane_cnt [LANE_CNT]
);

    int fail_cnt = 0;

    // replies sent and not yet credited back, seen from the ports
    logic [OUT_CNT_W-1:0]   in_flight;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end
        else begin
            in_flight <= in_flight + OUT_CNT_W'(reply_valid) - OUT_CNT_W'(reply_credit);
        end
    end

    a_send_needs_credit: assert property (@(posedge clk) disable iff (rst)
        reply_valid |-> (in_flight < OUT_CNT_W'(OUT_CREDITS)))
    else begin
        $error("reply sent with no output credit");
        fail_cnt++;
    end

    a_out_cnt_max: assert property (@(posedge clk) disable iff (rst)
        out_cnt <= OUT_CNT_W'(OUT_CREDITS))
    else begin
        $error("output credit counter above its start value");
        fail_cnt++;
    end

    a_reply_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(reply_valid))
    else begin
        $error("reply_valid unknown after reset");
        fail_cnt++;
    end

    for (genvar g = 0; g < LANE_CNT; g++) begin : g_lane_cnt
        a_lane_cnt_max: assert property (@(posedge clk) disable iff (rst)
            lane_cnt[g] <= HDR_CNT_W'(HDR_DEPTH))
        else begin
            $error("lane %0d credit counter above its start value", g);
            fail_cnt++;
        end
    end
endmodule

bind tcp_rx_top tcp_rx_assert i_tcp_rx_assert (
     .clk           (clk)
    ,.rst           (rst)
    ,.reply_valid   (reply_valid)
    ,.reply_credit  (reply_credit)
    ,.out_cnt       (i_arbiter.out_cnt)
    ,.lane_cnt      (i_dispatch.lane_cnt)
);

// ==== sim/tb_tcp_rx.sv ====
`timescale 1ns/10ps
module tb_tcp_rx
import tcp_rx_pkg::*;
();

    logic                   clk;
    logic                   rst;
    logic                   hdr_valid;
    logic [FLOWID_W-1:0]    hdr_flowid;
    logic [FLAGS_W-1:0]     hdr_flags;
    logic [SEQ_W-1:0]       hdr_seq;
    logic [SEQ_W-1:0]       hdr_ack;
    logic                   hdr_credit;
    logic                   reply_valid;
    logic [FLOWID_W-1:0]    reply_flowid;
    logic [FLAGS_W-1:0]     reply_flags;
    logic [SEQ_W-1:0]       reply_seq;
    logic [SEQ_W-1:0]       reply_ack;
    logic                   reply_credit;

    integer                 seed;
    int                     errors;
    int                     sent_cnt;
    int                     hcred_cnt;
    int                     rcv_cnt;
    int                     crd_ret_cnt;
    int                     exp_total;
    bit                     credit_on;
    flow_state_e            mstate [FLOW_CNT];
    reply_hdr_t             exp_q [FLOW_CNT][$];
    // SYN, ACK, FIN+ACK, RST, PSH+ACK
    logic [FLAGS_W-1:0]     flag_set [5];

    tcp_rx_top i_tcp_rx_top (
         .clk           (clk)
        ,.rst           (rst)
        ,.hdr_valid     (hdr_valid)
        ,.hdr_flowid    (hdr_flowid)
        ,.hdr_flags     (hdr_flags)
        ,.hdr_seq       (hdr_seq)
        ,.hdr_ack       (hdr_ack)
        ,.hdr_credit    (hdr_credit)
        ,.reply_valid   (reply_valid)
        ,.reply_flowid  (reply_flowid)
        ,.reply_flags   (reply_flags)
        ,.reply_seq     (reply_seq)
        ,.reply_ack     (reply_ack)
        ,.reply_credit  (reply_credit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reply scoreboard and credit counting
    always @(posedge clk) begin
        reply_hdr_t exp_hdr;
        if (!rst && hdr_credit) begin
            hcred_cnt++;
        end
        if (!rst && reply_valid) begin
            rcv_cnt++;
            if (exp_q[reply_flowid].size() == 0) begin
                errors++;
                $display("error %0t: unexpected reply on flow %0d", $time, reply_flowid);
            end
            else begin
                exp_hdr = exp_q[reply_flowid].pop_front();
                if ({reply_flowid, reply_flags, reply_seq, reply_ack} != exp_hdr) begin
                    errors++;
                    $display("error %0t: flow %0d got %h %h %h expected %h %h %h",
                             $time, reply_flowid, reply_flags, reply_seq, reply_ack,
                             exp_hdr.flags, exp_hdr.seq, exp_hdr.ack);
                end
            end
        end
    end

    function automatic void model_apply(input int f, input logic [FLAGS_W-1:0] flags,
                                        input logic [SEQ_W-1:0] seq,
                                        input logic [SEQ_W-1:0] ack);
        reply_hdr_t r;
        r        = '0;
        r.flowid = FLOWID_W'(f);
        if (flags[FLAG_RST]) begin
            mstate[f] = ST_NONE;
        end
        else if (flags[FLAG_SYN] && !flags[FLAG_ACK] && (mstate[f] == ST_NONE)) begin
            mstate[f] = ST_SYN_RCVD;
            r.flags   = 8'h12;
            r.seq     = 32'h0000_1000;
            r.ack     = seq + 1;
            exp_q[f].push_back(r);
            exp_total++;
        end
        else if (flags[FLAG_ACK] && !flags[FLAG_SYN] && !flags[FLAG_FIN]
                 && (mstate[f] == ST_SYN_RCVD)) begin
            mstate[f] = ST_EST;
        end
        else if (flags[FLAG_FIN] && (mstate[f] == ST_EST)) begin
            mstate[f] = ST_NONE;
            r.flags   = 8'h10;
            r.seq     = ack;
            r.ack     = seq + 1;
            exp_q[f].push_back(r);
            exp_total++;
        end
    endfunction

    function automatic int pending_count();
        int n;
        n = (sent_cnt - hcred_cnt) + (rcv_cnt - crd_ret_cnt);
        for (int f = 0; f < FLOW_CNT; f++) begin
            n += exp_q[f].size();
        end
        return n;
    endfunction

    // falling edge drive, reply credits returned at random
    task automatic next_cycle();
        @(negedge clk);
        hdr_valid    = 1'b0;
        reply_credit = 1'b0;
        if (credit_on && (rcv_cnt > crd_ret_cnt) && $random(seed) % 2 == 0) begin
            reply_credit = 1'b1;
            crd_ret_cnt++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic try_send(input int f, input logic [FLAGS_W-1:0] flags,
                            input logic [SEQ_W-1:0] seq, input logic [SEQ_W-1:0] ack,
                            output bit sent);
        int waited;
        waited = 0;
        next_cycle();
        while ((sent_cnt - hcred_cnt >= IN_DEPTH) && (waited < 100)) begin
            next_cycle();
            waited++;
        end
        sent = (sent_cnt - hcred_cnt < IN_DEPTH);
        if (sent) begin
            hdr_valid  = 1'b1;
            hdr_flowid = FLOWID_W'(f);
            hdr_flags  = flags;
            hdr_seq    = seq;
            hdr_ack    = ack;
            sent_cnt++;
            model_apply(f, flags, seq, ack);
        end
    endtask

    task automatic send_hdr(input int f, input logic [FLAGS_W-1:0] flags,
                            input logic [SEQ_W-1:0] seq, input logic [SEQ_W-1:0] ack);
        bit sent;
        try_send(f, flags, seq, ack, sent);
        if (!sent) begin
            abort_run("no input credit came back for the next header");
        end
    endtask

    task automatic drain(input string phase);
        int waited;
        waited = 0;
        while ((pending_count() != 0) && (waited < 2000)) begin
            next_cycle();
            waited++;
        end
        if (pending_count() != 0) begin
            errors++;
            $display("drain after %s did not finish, %0d items outstanding",
                     phase, pending_count());
        end
    endtask

    initial begin
        int                 f;
        int                 pick;
        int                 start_rcv;
        int                 af;
        bit                 sent;
        logic [SEQ_W-1:0]   s;
        logic [SEQ_W-1:0]   a;
        seed         = 76;
        errors       = 0;
        sent_cnt     = 0;
        hcred_cnt    = 0;
        rcv_cnt      = 0;
        crd_ret_cnt  = 0;
        exp_total    = 0;
        credit_on    = 1'b1;
        flag_set[0]  = 8'h02;
        flag_set[1]  = 8'h10;
        flag_set[2]  = 8'h11;
        flag_set[3]  = 8'h04;
        flag_set[4]  = 8'h18;
        for (int k = 0; k < FLOW_CNT; k++) begin
            mstate[k] = ST_NONE;
        end
        rst          = 1'b1;
        hdr_valid    = 1'b0;
        hdr_flowid   = '0;
        hdr_flags    = '0;
        hdr_seq      = '0;
        hdr_ack      = '0;
        reply_credit = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // open and close on one flow
        send_hdr(5, flag_set[0], 32'h0000_0100, 32'h0);
        send_hdr(5, flag_set[1], 32'h0000_0101, 32'h0000_1001);
        send_hdr(5, flag_set[2], 32'h0000_0101, 32'h0000_1001);
        drain("open and close");

        start_rcv = rcv_cnt;
        send_hdr(9, flag_set[3], 32'h0000_0200, 32'h0);
        send_hdr(9, flag_set[4], 32'h0000_0201, 32'h0);
        drain("rst and psh");
        if (rcv_cnt != start_rcv) begin
            errors++;
            $display("error %0t: rst or psh header drew a reply", $time);
        end
        send_hdr(6, flag_set[0], 32'h0000_0300, 32'h0);
        send_hdr(6, flag_set[3], 32'h0000_0301, 32'h0);
        send_hdr(6, flag_set[0], 32'h0000_0400, 32'h0);
        drain("reopen after rst");

        for (int i = 0; i < 400; i++) begin
            f    = $unsigned($random(seed)) % FLOW_CNT;
            pick = $unsigned($random(seed)) % 5;
            s    = $random(seed);
            a    = $random(seed);
            send_hdr(f, flag_set[pick], s, a);
        end
        drain("random traffic");

        // back-pressure: clear all flows, then withhold reply credits
        for (int k = 0; k < FLOW_CNT; k++) begin
            send_hdr(k, flag_set[3], 32'h0, 32'h0);
        end
        drain("flow clear");
        credit_on = 1'b0;
        start_rcv = rcv_cnt;
        sent      = 1'b1;
        for (int i = 0; (i < 64) && sent; i++) begin
            s = $random(seed);
            try_send((i / 2) % FLOW_CNT, (i % 2 == 0) ? flag_set[3] : flag_set[0], s, 32'h0,
                     sent);
        end
        if (sent) begin
            errors++;
            $display("hdr_credit kept coming while reply credits were withheld");
        end
        if (rcv_cnt - start_rcv != OUT_CREDITS) begin
            errors++;
            $display("error %0t: %0d replies with credits withheld, expected %0d",
                     $time, rcv_cnt - start_rcv, OUT_CREDITS);
        end
        credit_on = 1'b1;
        drain("credit release");

        if (hcred_cnt != sent_cnt) begin
            errors++;
            $display("error %0t: %0d hdr_credit pulses for %0d headers",
                     $time, hcred_cnt, sent_cnt);
        end
        if (rcv_cnt != exp_total) begin
            errors++;
            $display("error %0t: %0d replies, expected %0d", $time, rcv_cnt, exp_total);
        end
        for (int k = 0; k < FLOW_CNT; k++) begin
            if (exp_q[k].size() != 0) begin
                errors++;
                $display("error %0t: flow %0d missing %0d replies", $time, k, exp_q[k].size());
            end
        end
        af = i_tcp_rx_top.i_tcp_rx_assert.fail_cnt;
        $display("done: %0d errors, %0d assertion failures, %0d headers, %0d replies",
                 errors, af, sent_cnt, rcv_cnt);
        if ((errors == 0) && (af == 0)) begin
            $display("RESULT: PASS");
        end
        else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end
endmodule

// ==== build.f ====
hw/tcp_rx_pkg.sv
hw/credit_fifo.sv
hw/tcp_state_decide.sv
hw/rx_hdr_dispatch.sv
hw/rx_flow_lane.sv
hw/reply_arbiter.sv
hw/tcp_rx_top.sv
sim/tcp_rx_assert.sv
sim/tb_tcp_rx.sv

// ==== Bender.yml ====
package:
  name: tcp_rx

sources:
  - files:
      - hw/tcp_rx_pkg.sv
      - hw/credit_fifo.sv
      - hw/tcp_state_decide.sv
      - hw/rx_hdr_dispatch.sv
      - hw/rx_flow_lane.sv
      - hw/reply_arbiter.sv
      - hw/tcp_rx_top.sv
  - target: simulation
    files:
      - sim/tcp_rx_assert.sv
      - sim/tb_tcp_rx.sv
